// File: Makefile
# Verilator build for the oscillator voice testbench
# Override on the command line, e.g. make BUILD_DIR=out

VERILATOR ?= verilator
TOP       ?= osc_voice_tb
RTL_TOP   ?= osc_voice
BUILD_DIR ?= build
FILE_LIST ?= sim.f
VFLAGS    ?= --binary --timing -j 0

RTL_SRCS = source/osc_pkg.sv \
           source/osc_period_timer.sv \
           source/osc_phase_fsm.sv \
           source/osc_wave_shaper.sv \
           source/osc_voice.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run's exit status carries pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
source/osc_pkg.sv
source/osc_period_timer.sv
source/osc_phase_fsm.sv
source/osc_wave_shaper.sv
source/osc_voice.sv
sim/osc_voice_tb.sv

// File: sim/osc_voice_tb.sv
// Testbench for the oscillator voice
// A cycle model and a reference function predict every sample and strobe
// Random settings stay legal, with period from 2 to MAX_PERIOD
`timescale 1ns/1ps
`default_nettype none

module osc_voice_tb import osc_pkg::*; ();

  localparam int MAX_PERIOD = 64;
  // Slack on top of the clocks that the tests are expected to take
  localparam int MARGIN     = 50;

  // Model phase codes that stay independent of the DUT encoding
  localparam int M_IDLE   = 0;
  localparam int M_RELOAD = 1;
  localparam int M_HIGH   = 2;
  localparam int M_LOW    = 3;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           enable;
  logic                           wave_sel;
  logic        [COUNT_WIDTH-1:0]  period;
  logic        [COUNT_WIDTH-1:0]  duty;
  logic signed [SAMPLE_WIDTH-1:0] sample;
  logic                           cycle_start;

  // Cycle model state
  int                             m_phase;
  int                             m_count;
  int                             m_period;
  int                             m_duty;
  logic                           m_wave;
  logic signed [SAMPLE_WIDTH-1:0] exp_sample;
  logic                           exp_start;

  int seed;
  int cycle_count  = 0;
  int cycle_budget = MARGIN;

  osc_voice i_osc_voice (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .wave_sel    (wave_sel),
    .period      (period),
    .duty        (duty),
    .sample      (sample),
    .cycle_start (cycle_start)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Pulse is full scale high then low and ramp is the count in offset binary
  function automatic logic signed [SAMPLE_WIDTH-1:0] expected_sample(
    input int   phase_code,
    input int   cnt,
    input logic wave
  );
    logic signed [SAMPLE_WIDTH-1:0] ramp;
    ramp = SAMPLE_WIDTH'(cnt - (1 << (COUNT_WIDTH - 1)));
    if (phase_code == M_HIGH) begin
      expected_sample = (wave == WAVE_RAMP) ? ramp : SAMPLE_MAX;
    end else if (phase_code == M_LOW) begin
      expected_sample = (wave == WAVE_RAMP) ? ramp : SAMPLE_MIN;
    end else begin
      expected_sample = '0;
    end
  endfunction

  // Steps the model on each edge and sets the outputs that the DUT shows after that edge
  always @(posedge clk or negedge rst_n) begin : model_step
    int next_phase;
    if (!rst_n) begin
      m_phase    = M_IDLE;
      m_count    = 0;
      m_wave     = WAVE_PULSE;
      exp_sample = '0;
      exp_start  = 1'b0;
    end else begin
      exp_sample = expected_sample(m_phase, m_count, m_wave);
      exp_start  = (m_phase == M_RELOAD);
      next_phase = m_phase;
      case (m_phase)
        M_IDLE:   next_phase = M_RELOAD;
        M_RELOAD: next_phase = M_HIGH;
        M_HIGH:   if (m_count == m_duty - 1) next_phase = M_LOW;
        M_LOW:    if (m_count == m_period - 1) next_phase = M_RELOAD;
        default:  next_phase = M_IDLE;
      endcase
      // A low enable overrides every other move
      if (!enable) next_phase = M_IDLE;
      if (m_phase == M_RELOAD) begin
        m_period = int'(period);
        m_duty   = int'(duty);
        m_wave   = wave_sel;
      end
      // The count runs through both active phases and parks at zero otherwise
      m_count = (m_phase == M_HIGH || m_phase == M_LOW) ? m_count + 1 : 0;
      m_phase = next_phase;
    end
  end

  //////////////////////////////
  // Compare and watchdog
  //////////////////////////////

  // Outputs are sampled on the falling edge where they have settled
  always @(negedge clk) begin
    assert (sample === exp_sample) else begin
      $display("mismatch at %0t ns: sample expected %0d got %0d", $time, exp_sample, sample);
      $display("Checks failed");
      $fatal(1, "sample differs from the model");
    end
    assert (cycle_start === exp_start) else begin
      $display("mismatch at %0t ns: cycle_start expected %0b got %0b",
               $time, exp_start, cycle_start);
      $display("Checks failed");
      $fatal(1, "cycle_start differs from the model");
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_budget) begin
      $display("Timeout after %0d clocks, the expected cycle start never came", cycle_count);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic add_budget(input int clocks);
    cycle_budget = cycle_budget + clocks;
  endtask

  task automatic apply_settings(input int p, input int d, input logic w);
    period   = COUNT_WIDTH'(p);
    duty     = COUNT_WIDTH'(d);
    wave_sel = w;
  endtask

  // Draws legal settings with period 2 to MAX_PERIOD and duty 1 to period minus 1
  task automatic random_settings(output int p, output int d, output logic w);
    p = 2 + int'($unsigned($random(seed)) % (MAX_PERIOD - 1));
    d = 1 + int'($unsigned($random(seed)) % (p - 1));
    w = 1'($random(seed) & 1);
  endtask

  // Returns right after the strobe is seen and the watchdog bounds the wait
  task automatic wait_cycle_start();
    do begin
      tick(1);
    end while (cycle_start !== 1'b1);
  endtask

  // Counts clocks from one strobe to the next
  task automatic check_cycle_length(input int p);
    int clocks;
    clocks = 0;
    do begin
      tick(1);
      clocks++;
    end while (cycle_start !== 1'b1);
    assert (clocks == p + 1) else begin
      $display("mismatch at %0t ns: cycle_start spacing expected %0d got %0d",
               $time, p + 1, clocks);
      $display("Checks failed");
      $fatal(1, "cycle length differs from period plus one");
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : stimulus
    int   p;
    int   d;
    logic w;
    int   cur_p;

    seed     = 56;
    rst_n    = 1'b0;
    enable   = 1'b0;
    wave_sel = WAVE_PULSE;
    period   = COUNT_WIDTH'(10);
    duty     = COUNT_WIDTH'(3);

    // Reset for two clocks, then stay disabled for a while
    add_budget(12);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick(8);

    // Pulse wave with period 10 and duty 3
    add_budget(4 * 11 + 4);
    enable = 1'b1;
    wait_cycle_start();
    repeat (3) check_cycle_length(10);
    cur_p = 10;

    // Ramp wave over random periods
    repeat (4) begin
      random_settings(p, d, w);
      apply_settings(p, d, WAVE_RAMP);
      add_budget(cur_p + p + 4);
      wait_cycle_start();
      check_cycle_length(p);
      cur_p = p;
    end

    // New settings in mid cycle must wait for the next reload
    apply_settings(10, 3, WAVE_PULSE);
    add_budget(cur_p + 11 + 7 + 8);
    wait_cycle_start();
    tick(4);
    apply_settings(6, 2, WAVE_RAMP);
    wait_cycle_start();
    check_cycle_length(6);
    cur_p = 6;

    // Drop enable in mid cycle, then restart with a fresh reload
    add_budget(3 + 4 + 2 + 7 + 4);
    tick(3);
    enable = 1'b0;
    tick(4);
    enable = 1'b1;
    wait_cycle_start();
    check_cycle_length(6);

    // Random settings and waveform with one new set per cycle
    repeat (20) begin
      random_settings(p, d, w);
      apply_settings(p, d, w);
      add_budget(cur_p + 3);
      wait_cycle_start();
      cur_p = p;
    end
    add_budget(cur_p + 3);
    check_cycle_length(cur_p);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/osc_period_timer.sv
// Period counter of the voice
// Needs period >= 2 and 1 <= duty <= period - 1, other settings are not handled
// Settings are sampled only while the phase is PHASE_RELOAD
`timescale 1ns/1ps
`default_nettype none

module osc_period_timer import osc_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  phase_t                 phase,
  input  logic [COUNT_WIDTH-1:0] period,
  input  logic [COUNT_WIDTH-1:0] duty,
  output logic [COUNT_WIDTH-1:0] count,
  output logic                   duty_hit,
  output logic                   period_hit
);

  // Settings held for the whole cycle
  logic [COUNT_WIDTH-1:0] period_q;
  logic [COUNT_WIDTH-1:0] duty_q;

  // Last count value of each phase
  logic [COUNT_WIDTH-1:0] duty_last;
  logic [COUNT_WIDTH-1:0] period_last;

  //////////////////////////////
  // Settings latch
  //////////////////////////////

  // Only the reload phase opens the latch, so mid-cycle input changes wait
  always_ff @(posedge clk) begin
    if (phase == PHASE_RELOAD) begin
      period_q <= period;
      duty_q   <= duty;
    end
  end

  //////////////////////////////
  // Running count
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case (phase)
        // The count runs on through both active phases without a restart
        PHASE_HIGH, PHASE_LOW: count <= count + COUNT_WIDTH'(1);
        // Idle and reload both park the count at zero
        default:               count <= '0;
      endcase
    end
  end

  // End point flags, each valid only inside its own phase
  assign duty_last   = duty_q - COUNT_WIDTH'(1);
  assign period_last = period_q - COUNT_WIDTH'(1);

  assign duty_hit   = (phase == PHASE_HIGH) && (count == duty_last);
  assign period_hit = (phase == PHASE_LOW) && (count == period_last);

endmodule

`default_nettype wire

// File: source/osc_phase_fsm.sv
// Phase sequencer of the voice
// Reacts to the timer flags only and makes no count compares of its own
// A low enable wins over every other transition
`timescale 1ns/1ps
`default_nettype none

module osc_phase_fsm import osc_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   enable,
  input  logic   duty_hit,
  input  logic   period_hit,
  output phase_t phase
);

  phase_t phase_next;

  //////////////////////////////
  // Next state logic
  //////////////////////////////

  always_comb begin
    phase_next = phase;

    if (!enable) begin
      // Disable drops the voice straight to idle from any phase
      phase_next = PHASE_IDLE;
    end else begin
      case (phase)
        PHASE_IDLE: begin
          // First enabled edge starts a fresh cycle with a reload
          phase_next = PHASE_RELOAD;
        end

        PHASE_RELOAD: begin
          // Reload lasts a single clock
          phase_next = PHASE_HIGH;
        end

        PHASE_HIGH: begin
          // Leave the high part once the count reaches duty minus one
          if (duty_hit) begin
            phase_next = PHASE_LOW;
          end
        end

        PHASE_LOW: begin
          // End of period goes back to reload for the next cycle
          if (period_hit) begin
            phase_next = PHASE_RELOAD;
          end
        end

        default: begin
          phase_next = PHASE_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Phase register
  //////////////////////////////

  // One full cycle spans period plus one clocks:
  // reload, then duty clocks high, then period minus duty clocks low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= PHASE_IDLE;
    end else begin
      phase <= phase_next;
    end
  end

endmodule

`default_nettype wire

// File: source/osc_pkg.sv
// Shared widths, phase encoding and waveform codes for the oscillator voice
// Count and sample widths are fixed here; the ramp mapping expects them equal
`default_nettype none

package osc_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Period, duty and running count all use this width
  localparam int COUNT_WIDTH  = 16;
  // Output samples are signed two's complement
  localparam int SAMPLE_WIDTH = 16;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Voice phase as stepped by the sequencer
  typedef enum logic [1:0] {
    PHASE_IDLE   = 2'd0,
    PHASE_RELOAD = 2'd1,
    PHASE_HIGH   = 2'd2,
    PHASE_LOW    = 2'd3
  } phase_t;

  // Waveform select input codes
  localparam logic WAVE_PULSE = 1'b0;
  localparam logic WAVE_RAMP  = 1'b1;

  // Full scale levels of the pulse wave
  localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
  localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

endpackage

`default_nettype wire

// File: source/osc_voice.sv
// Single oscillator voice with a pulse or ramp output
// Settings are taken at each reload; illegal period or duty is not handled
// Produces one sample per clock with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module osc_voice import osc_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           enable,
  input  logic                           wave_sel,
  input  logic        [COUNT_WIDTH-1:0]  period,
  input  logic        [COUNT_WIDTH-1:0]  duty,
  output logic signed [SAMPLE_WIDTH-1:0] sample,
  output logic                           cycle_start
);

  // Shared phase from the sequencer
  phase_t phase;

  // Timer results
  logic [COUNT_WIDTH-1:0] count;
  logic                   duty_hit;
  logic                   period_hit;

  //////////////////////////////
  // Sequencer and timer
  //////////////////////////////

  // The timer owns the end point compares, the sequencer only follows them
  osc_phase_fsm i_osc_phase_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .duty_hit   (duty_hit),
    .period_hit (period_hit),
    .phase      (phase)
  );

  osc_period_timer i_osc_period_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase),
    .period     (period),
    .duty       (duty),
    .count      (count),
    .duty_hit   (duty_hit),
    .period_hit (period_hit)
  );

  //////////////////////////////
  // Output stage
  //////////////////////////////

  osc_wave_shaper i_osc_wave_shaper (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .count       (count),
    .wave_sel    (wave_sel),
    .sample      (sample),
    .cycle_start (cycle_start)
  );

endmodule

`default_nettype wire

// File: source/osc_wave_shaper.sv
// Sample generator for pulse and ramp waves
// Output is registered, so it trails the phase and count by one clock
// The ramp mapping assumes COUNT_WIDTH equals SAMPLE_WIDTH
`timescale 1ns/1ps
`default_nettype none

module osc_wave_shaper import osc_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  phase_t                         phase,
  input  logic        [COUNT_WIDTH-1:0]  count,
  input  logic                           wave_sel,
  output logic signed [SAMPLE_WIDTH-1:0] sample,
  output logic                           cycle_start
);

  // Waveform in use for the current cycle
  logic wave_q;

  logic signed [SAMPLE_WIDTH-1:0] ramp_value;
  logic signed [SAMPLE_WIDTH-1:0] sample_next;

  //////////////////////////////
  // Select latch
  //////////////////////////////

  // Changes of the select only land at the start of a cycle
  always_ff @(posedge clk) begin
    if (phase == PHASE_RELOAD) begin
      wave_q <= wave_sel;
    end
  end

  //////////////////////////////
  // Sample selection
  //////////////////////////////

  // Flipping the top bit turns the unsigned count into a signed rising ramp
  assign ramp_value = signed'({~count[COUNT_WIDTH-1], count[COUNT_WIDTH-2:0]});

  always_comb begin
    case (phase)
      PHASE_HIGH: sample_next = (wave_q == WAVE_PULSE) ? SAMPLE_MAX : ramp_value;
      PHASE_LOW:  sample_next = (wave_q == WAVE_PULSE) ? SAMPLE_MIN : ramp_value;
      // Idle and reload output silence in either mode
      default:    sample_next = '0;
    endcase
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////

  // The start strobe shares the sample's one clock delay
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample      <= '0;
      cycle_start <= 1'b0;
    end else begin
      sample      <= sample_next;
      cycle_start <= (phase == PHASE_RELOAD);
    end
  end

endmodule

`default_nettype wire
